// ==== eth_loop_pkg.sv ====
`default_nettype none

package eth_loop_pkg;

	// default sizes, the top level takes these and passes them down.
	localparam int num_scripts_default = 2;
	localparam int max_script_size_default = 64; // script words per memory.
	localparam int axi_width_default = 32; // host data width.

	// one script word per byte position and script.
	localparam int script_word_bits = 32;

	// edit op codes, anything else acts as nop.
	localparam logic [7:0] op_nop = 8'd0;
	localparam logic [7:0] op_set = 8'd1; // byte = param.
	localparam logic [7:0] op_xor = 8'd2;
	localparam logic [7:0] op_and = 8'd3;
	localparam logic [7:0] op_or = 8'd4;

	// field positions inside a script word.
	// layout is {param_b, param_a, instr_b, instr_a}.
	localparam int instr_a_lsb = 0;
	localparam int instr_b_lsb = 8;
	localparam int param_a_lsb = 16;
	localparam int param_b_lsb = 24;

endpackage

`default_nettype wire

// ==== script_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module script_mem #(
	parameter int axi_width = 32,
	parameter int max_script_size = 64
) (
	input wire logic clk,
	input wire logic rst_n,

	// host port.
	input wire logic [$clog2(max_script_size)-1:0] addr,
	input wire logic [axi_width-1:0] wdata,
	input wire logic we,
	input wire logic req,
	output logic [axi_width-1:0] rdata,
	output logic ack,

	// frame position port.
	input wire logic [$clog2(max_script_size)-1:0] rd_pos,
	output logic [axi_width-1:0] pos_data
);

	logic [axi_width-1:0] mem [max_script_size];

	// host side, read returns the old word even on a write.
	always_ff @(posedge clk) begin
		if (req) begin
			rdata <= mem[addr];
			if (we)
				mem[addr] <= wdata;
		end
	end

	// one ack per request, exactly one cycle later.
	always_ff @(posedge clk) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= req;
	end

	// registered position read, runs every cycle.
	always_ff @(posedge clk) begin
		pos_data <= mem[rd_pos];
	end

endmodule

`default_nettype wire

// ==== eth_frame_loop_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_frame_loop_rx import eth_loop_pkg::*; #(
	parameter int num_scripts = 2,
	parameter int axi_width = 32,
	parameter int max_script_size = 64
) (
	input wire logic clk,
	input wire logic rst_n,

	// host bus.
	input wire logic mem_req,
	input wire logic [$clog2(num_scripts)+$clog2(max_script_size)+1:0] mem_addr,
	input wire logic mem_wenable,
	input wire logic [axi_width-1:0] mem_wdata,
	output logic [axi_width-1:0] mem_rdata,
	output logic mem_ack,

	// received byte stream.
	input wire logic [7:0] s_axis_tdata,
	input wire logic s_axis_tuser,
	input wire logic s_axis_tlast,
	input wire logic s_axis_tvalid,

	// tagged stream towards the editor.
	output logic [7:0] rx_tdata,
	output logic [script_word_bits*num_scripts:0] rx_tuser, // {scripts, frame_bad}.
	output logic rx_tlast,
	output logic rx_tvalid
);

	localparam int pos_bits = $clog2(max_script_size);
	localparam int sel_bits = $clog2(num_scripts);
	localparam int addr_bits = sel_bits + pos_bits + 2;

	logic [pos_bits-1:0] count; // position of the next byte.
	logic script_end;

	logic [num_scripts-1:0] sel_hit;
	logic [num_scripts-1:0] host_ack;
	logic [axi_width-1:0] host_rdata [num_scripts];
	logic [script_word_bits*num_scripts-1:0] pos_words;

	// first stage, lines up with the registered script read.
	logic [7:0] d1_tdata;
	logic d1_bad;
	logic d1_tlast;
	logic d1_tvalid;
	logic d1_end; // byte lies past the scripted prefix.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			script_end <= 1'b0;
		end else if (s_axis_tvalid) begin
			if (s_axis_tlast) begin
				count <= '0;
				script_end <= 1'b0;
			end else if (count != pos_bits'(max_script_size - 1)) begin
				count <= count + 1'b1;
			end else begin
				script_end <= 1'b1; // count holds at the last word.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d1_tlast <= 1'b0;
			d1_tvalid <= 1'b0;
			rx_tlast <= 1'b0;
			rx_tvalid <= 1'b0;
		end else begin
			d1_tlast <= s_axis_tlast;
			d1_tvalid <= s_axis_tvalid;
			rx_tlast <= d1_tlast;
			rx_tvalid <= d1_tvalid;
		end
	end

	always_ff @(posedge clk) begin
		d1_tdata <= s_axis_tdata;
		d1_bad <= s_axis_tuser;
		d1_end <= script_end || (count == pos_bits'(max_script_size - 1));
		rx_tdata <= d1_tdata;
		rx_tuser <= {(d1_end ? '0 : pos_words), d1_bad};
	end

	// host address decode, upper bits pick the script.
	if (num_scripts == 1) begin : g_single
		assign sel_hit = 1'b1;
		assign mem_rdata = host_rdata[0];
		assign mem_ack = host_ack[0];
	end else begin : g_multi
		logic [sel_bits-1:0] script_sel;

		assign script_sel = mem_addr[addr_bits-1 -: sel_bits];

		always_comb begin
			for (int i = 0; i < num_scripts; i++)
				sel_hit[i] = (int'(script_sel) == i);
			if (int'(script_sel) < num_scripts) begin
				mem_rdata = host_rdata[script_sel];
				mem_ack = host_ack[script_sel];
			end else begin
				mem_rdata = '0; // no memory behind this address.
				mem_ack = 1'b0;
			end
		end
	end

	for (genvar i = 0; i < num_scripts; i++) begin : g_script
		script_mem #(
			.axi_width(axi_width),
			.max_script_size(max_script_size)
		) u_script_mem (
			.clk(clk),
			.rst_n(rst_n),
			.addr(mem_addr[pos_bits+1:2]),
			.wdata(mem_wdata),
			.we(mem_wenable && sel_hit[i]),
			.req(mem_req && sel_hit[i]),
			.rdata(host_rdata[i]),
			.ack(host_ack[i]),
			.rd_pos(count),
			.pos_data(pos_words[script_word_bits*i +: script_word_bits])
		);
	end

endmodule

`default_nettype wire

// ==== eth_frame_loop_edit.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_frame_loop_edit import eth_loop_pkg::*; #(
	parameter int num_scripts = 2
) (
	input wire logic clk,
	input wire logic rst_n,

	// tagged stream from the receiver.
	input wire logic [7:0] rx_tdata,
	input wire logic [script_word_bits*num_scripts:0] rx_tuser,
	input wire logic rx_tlast,
	input wire logic rx_tvalid,

	// edited output stream.
	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser, // frame_bad.
	output logic m_axis_tlast,
	output logic m_axis_tvalid
);

	logic [7:0] edit_byte;

	// one edit step.
	function automatic logic [7:0] apply_op(
		input logic [7:0] op,
		input logic [7:0] data,
		input logic [7:0] param
	);
		logic [7:0] res;

		case (op)
			op_nop: res = data;
			op_set: res = param;
			op_xor: res = data ^ param;
			op_and: res = data & param;
			op_or: res = data | param;
			default: res = data; // unknown code leaves the byte alone.
		endcase
		return res;
	endfunction

	// scripts in order, each one does instr_a then instr_b.
	always_comb begin
		logic [script_word_bits-1:0] word;

		edit_byte = rx_tdata;
		for (int i = 0; i < num_scripts; i++) begin
			word = rx_tuser[script_word_bits*i+1 +: script_word_bits]; // skip frame_bad.
			edit_byte = apply_op(word[instr_a_lsb +: 8], edit_byte, word[param_a_lsb +: 8]);
			edit_byte = apply_op(word[instr_b_lsb +: 8], edit_byte, word[param_b_lsb +: 8]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_axis_tlast <= 1'b0;
			m_axis_tvalid <= 1'b0;
		end else begin
			m_axis_tlast <= rx_tlast;
			m_axis_tvalid <= rx_tvalid;
		end
	end

	always_ff @(posedge clk) begin
		m_axis_tdata <= edit_byte;
		m_axis_tuser <= rx_tuser[0];
	end

endmodule

`default_nettype wire

// ==== eth_frame_loop.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_frame_loop import eth_loop_pkg::*; #(
	parameter int num_scripts = num_scripts_default,
	parameter int axi_width = axi_width_default,
	parameter int max_script_size = max_script_size_default
) (
	input wire logic clk,
	input wire logic rst_n,

	// host bus, byte addressed.
	input wire logic mem_req,
	input wire logic [$clog2(num_scripts)+$clog2(max_script_size)+1:0] mem_addr,
	input wire logic mem_wenable,
	input wire logic [axi_width-1:0] mem_wdata,
	output logic [axi_width-1:0] mem_rdata,
	output logic mem_ack,

	// received frames.
	input wire logic [7:0] s_axis_tdata,
	input wire logic s_axis_tuser,
	input wire logic s_axis_tlast,
	input wire logic s_axis_tvalid,

	// edited frames, 3 cycles behind the input.
	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid
);

	logic [7:0] rx_tdata;
	logic [script_word_bits*num_scripts:0] rx_tuser;
	logic rx_tlast;
	logic rx_tvalid;

	eth_frame_loop_rx #(
		.num_scripts(num_scripts),
		.axi_width(axi_width),
		.max_script_size(max_script_size)
	) u_rx (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.rx_tdata(rx_tdata),
		.rx_tuser(rx_tuser),
		.rx_tlast(rx_tlast),
		.rx_tvalid(rx_tvalid)
	);

	eth_frame_loop_edit #(
		.num_scripts(num_scripts)
	) u_edit (
		.clk(clk),
		.rst_n(rst_n),
		.rx_tdata(rx_tdata),
		.rx_tuser(rx_tuser),
		.rx_tlast(rx_tlast),
		.rx_tvalid(rx_tvalid),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid)
	);

endmodule

`default_nettype wire

// ==== tb_eth_frame_loop.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_eth_frame_loop;

	localparam int nscripts = 2;
	localparam int script_size = 64;
	localparam int ack_timeout = 8;
	localparam int drain_timeout = 300;

	logic clk;
	logic rst_n;
	logic mem_req;
	logic [8:0] mem_addr; // {script, word, byte}.
	logic mem_wenable;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic mem_ack;
	logic [7:0] s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	logic [7:0] m_axis_tdata;
	logic m_axis_tuser;
	logic m_axis_tlast;
	logic m_axis_tvalid;

	logic [31:0] script_copy [nscripts][script_size]; // host view of every script word.
	logic [31:0] rand_state;
	logic [7:0] exp_data [$];
	logic exp_bad [$];
	logic exp_last [$];
	int exp_cycle [$]; // cycle at which the byte was driven.
	int cycle_count;
	string test_name;

	eth_frame_loop #(
		.num_scripts(nscripts),
		.axi_width(32),
		.max_script_size(script_size)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// random ops 0..7, so codes 5..7 act as nop.
	function automatic logic [31:0] random_script_word();
		logic [31:0] r1;
		logic [31:0] r2;

		r1 = next_random();
		r2 = next_random();
		return {r1[31:24], r1[23:16], 5'd0, r2[30:28], 5'd0, r2[26:24]};
	endfunction

	// edit rule: 1 set, 2 xor, 3 and, 4 or, anything else keeps the byte.
	function automatic logic [7:0] step_result(input logic [7:0] op, input logic [7:0] data,
			input logic [7:0] param);
		case (op)
			8'd1: return param;
			8'd2: return data ^ param;
			8'd3: return data & param;
			8'd4: return data | param;
			default: return data;
		endcase
	endfunction

	function automatic logic [7:0] expected_byte(input int pos, input logic [7:0] data);
		logic [7:0] d;
		logic [31:0] w;

		d = data;
		if (pos < script_size - 1) begin // the last position already counts as past the end.
			for (int s = 0; s < nscripts; s++) begin
				w = script_copy[s][pos];
				d = step_result(w[7:0], d, w[23:16]);
				d = step_result(w[15:8], d, w[31:24]);
			end
		end
		return d;
	endfunction

	task automatic stop_on_failure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
		stop_on_failure();
	endtask

	task automatic host_access(input int sel, input int word, input logic write,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;

		@(negedge clk);
		mem_req = 1'b1;
		mem_wenable = write;
		mem_addr = {sel[0], word[5:0], 2'b00};
		mem_wdata = wdata;
		waited = 0;
		do begin
			@(negedge clk);
			mem_req = 1'b0; // one-cycle strobe, address stays put.
			mem_wenable = 1'b0;
			waited++;
		end while (!mem_ack && waited < ack_timeout);
		if (!mem_ack) begin
			$display("no mem_ack within %0d cycles of a request in %s", ack_timeout, test_name);
			stop_on_failure();
		end
		assert (waited == 1) else report_mismatch("ack delay", 1, waited);
		rdata = mem_rdata;
	endtask

	task automatic host_write(input int sel, input int word, input logic [31:0] data);
		logic [31:0] old;

		host_access(sel, word, 1'b1, data, old);
		// a write hands back the word it replaces.
		assert ($isunknown(script_copy[sel][word]) || old === script_copy[sel][word])
		else report_mismatch("old word", script_copy[sel][word], old);
		script_copy[sel][word] = data;
	endtask

	task automatic host_read_check(input int sel, input int word);
		logic [31:0] rd;

		host_access(sel, word, 1'b0, 32'd0, rd);
		assert (rd === script_copy[sel][word])
		else report_mismatch("readback", script_copy[sel][word], rd);
	endtask

	// bytes go out on consecutive cycles, tvalid stays high afterwards.
	task automatic send_frame(input int len, input logic bad);
		logic [31:0] r;
		logic [7:0] data;

		for (int k = 0; k < len; k++) begin
			r = next_random();
			data = r[23:16];
			@(negedge clk);
			s_axis_tdata = data;
			s_axis_tuser = bad;
			s_axis_tlast = (k == len - 1);
			s_axis_tvalid = 1'b1;
			exp_data.push_back(expected_byte(k, data));
			exp_bad.push_back(bad);
			exp_last.push_back(k == len - 1);
			exp_cycle.push_back(cycle_count);
		end
	endtask

	task automatic go_idle();
		@(negedge clk);
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;

		waited = 0;
		while (exp_data.size() != 0 && waited < drain_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (exp_data.size() != 0) begin
			$display("%0d bytes never came out in %s", exp_data.size(), test_name);
			stop_on_failure();
		end
	endtask

	// outputs settle after the rising edge, so they are compared on the falling one.
	always @(negedge clk) begin
		if (rst_n && m_axis_tvalid) begin
			if (exp_data.size() == 0) begin
				$display("m_axis_tvalid high with no byte outstanding in %s", test_name);
				stop_on_failure();
			end else begin
				assert (cycle_count - exp_cycle[0] == 3)
				else report_mismatch("latency", 3, cycle_count - exp_cycle[0]);
				assert (m_axis_tdata === exp_data[0])
				else report_mismatch("tdata", exp_data[0], m_axis_tdata);
				assert (m_axis_tuser === exp_bad[0])
				else report_mismatch("frame_bad", exp_bad[0], m_axis_tuser);
				assert (m_axis_tlast === exp_last[0])
				else report_mismatch("tlast", exp_last[0], m_axis_tlast);
				void'(exp_data.pop_front());
				void'(exp_bad.pop_front());
				void'(exp_last.pop_front());
				void'(exp_cycle.pop_front());
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] w;
		int len;

		clk = 1'b0;
		rst_n = 1'b0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_wenable = 1'b0;
		mem_wdata = '0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		cycle_count = 0;
		rand_state = 32'hd86c119f;
		test_name = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		assert (m_axis_tvalid === 1'b0 && m_axis_tlast === 1'b0 && mem_ack === 1'b0)
		else report_mismatch("valid, last and ack", 0, {m_axis_tvalid, m_axis_tlast, mem_ack});
		rst_n = 1'b1;

		test_name = "host bus";
		for (int s = 0; s < nscripts; s++)
			for (int i = 0; i < script_size; i++)
				host_write(s, i, next_random());
		for (int s = 0; s < nscripts; s++)
			for (int i = 0; i < script_size; i++)
				host_read_check(s, i);

		test_name = "single script";
		for (int i = 0; i < script_size; i++) begin
			w = random_script_word();
			if (i < 8)
				w[7:0] = 8'(i); // every op code shows up at least once.
			host_write(0, i, w);
			host_write(1, i, 32'd0);
		end
		for (int f = 0; f < 4; f++) begin
			r = next_random();
			len = 10 + int'(r[31:16] % 31);
			send_frame(len, r[12]);
			go_idle();
		end
		wait_drain();

		test_name = "chained scripts";
		for (int s = 0; s < nscripts; s++)
			for (int i = 0; i < script_size; i++)
				host_write(s, i, random_script_word());
		for (int f = 0; f < 4; f++) begin
			r = next_random();
			len = 10 + int'(r[31:16] % 51);
			send_frame(len, r[9]);
			if (r[4])
				go_idle();
		end
		go_idle();
		wait_drain();

		test_name = "script end";
		host_write(0, script_size - 1, {8'h00, 8'h5a, 8'h00, 8'h01}); // set would show at 63.
		host_write(1, script_size - 1, {8'h00, 8'hff, 8'h00, 8'h02});
		send_frame(80, 1'b1);
		go_idle();
		wait_drain();

		test_name = "frame restart";
		fork
			begin
				send_frame(30, 1'b0);
				send_frame(25, 1'b1);
				send_frame(70, 1'b0);
			end
			begin
				repeat (15) @(negedge clk);
				host_write(1, 2, {8'h0f, 8'h33, 8'h02, 8'h01}); // frame is well past position 2.
			end
		join
		go_idle();
		wait_drain();
		repeat (6) @(negedge clk);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
eth_loop_pkg.sv
script_mem.sv
eth_frame_loop_rx.sv
eth_frame_loop_edit.sv
eth_frame_loop.sv
tb_eth_frame_loop.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_eth_frame_loop -f src.f

out=$(./obj_dir/Vtb_eth_frame_loop 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "No errors"; then
	exit 0
fi
exit 1
